//--- compile.f
verilog/ctu_pkg.sv
verilog/reset_repeater.sv
verilog/cluster_header.sv
verilog/ctu_sequencer.sv
verilog/ctu_top.sv
verif/ctu_checker.sv
verif/tb_ctu.sv

//--- Bender.yml
package:
  name: ctu

sources:
  - verilog/ctu_pkg.sv
  - verilog/reset_repeater.sv
  - verilog/cluster_header.sv
  - verilog/ctu_sequencer.sv
  - verilog/ctu_top.sv
  - target: test
    files:
      - verif/ctu_checker.sv
      - verif/tb_ctu.sv

//--- verif/tb_ctu.sv
/*
 * Testbench for ctu_top. Commands and scan data come from a fixed seed.
 * Every cycle, the outputs are compared with a cycle model of the
 * sequencer, the enable synchronizers and the repeater scan chain.
 * Outputs are sampled on the falling edge, where they are stable.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_ctu;

   localparam int CLK_PERIOD  = 20;
   // Random commands issued back to back
   localparam int NUM_CMDS    = 200;
   // Shift cycles in the scan phase flush the chain twice
   localparam int SCAN_CYCLES = 2 * ctu_pkg::SCAN_LEN;
   localparam int N           = ctu_pkg::NUM_CLUSTERS;
   localparam int D           = ctu_pkg::SYNC_DEPTH;
   localparam int L           = ctu_pkg::SCAN_LEN;

   logic                              gclk;
   logic                              rst_n;
   logic                              cmd_valid;
   logic [ctu_pkg::CMD_OP_W-1:0]      cmd_op;
   logic [ctu_pkg::CLUSTER_IDX_W-1:0] cmd_cluster;
   logic                              si;
   logic                              se;
   logic [N-1:0]                      cluster_en;
   logic [N-1:0]                      cluster_grst_l;
   logic [N-1:0]                      dbginit_l;
   logic                              so;

   // Model of the sequencer registers
   logic [N-1:0] m_cken;
   int           m_rst_cnt;
   int           m_dbg_cnt;
   logic         m_grst_l;
   logic         m_gdbg_l;
   // Enable synchronizer stages and the repeater flops in chain order
   logic [N-1:0] m_en_pipe [D];
   logic [L-1:0] m_chain;
   logic [N-1:0] m_grst_out;
   logic [N-1:0] m_dbg_out;

   int   vec_errors;
   int   bit_errors;
   int   assert_errors;
   logic checking;

   ctu_top ctu_top_i (
      .gclk           (gclk),
      .rst_n          (rst_n),
      .cmd_valid      (cmd_valid),
      .cmd_op         (cmd_op),
      .cmd_cluster    (cmd_cluster),
      .si             (si),
      .se             (se),
      .cluster_en     (cluster_en),
      .cluster_grst_l (cluster_grst_l),
      .dbginit_l      (dbginit_l),
      .so             (so)
   );

   initial begin
      gclk = 1'b0;
      forever #(CLK_PERIOD / 2) gclk = ~gclk;
   end

   // The model steps on each edge and reads the inputs as the DUT samples them
   always @(posedge gclk) begin : model_step
      logic [L-1:0] chain_nxt;
      if (!rst_n) begin
         m_cken    = '0;
         m_rst_cnt = 0;
         m_dbg_cnt = 0;
         m_grst_l  = 1'b0;
         m_gdbg_l  = 1'b0;
         m_chain   = '0;
         for (int s = 0; s < D; s++) begin
            m_en_pipe[s] = '0;
         end
      end else begin
         // Each header holds D reset flops followed by D debug-init flops
         if (se) begin
            chain_nxt = {m_chain[L-2:0], si};
         end else begin
            for (int i = 0; i < L; i++) begin
               if (i % D != 0) begin
                  chain_nxt[i] = m_chain[i-1];
               end else if ((i / D) % 2 == 0) begin
                  chain_nxt[i] = m_grst_l;
               end else begin
                  chain_nxt[i] = m_gdbg_l;
               end
            end
         end
         m_chain = chain_nxt;
         for (int s = D - 1; s > 0; s--) begin
            m_en_pipe[s] = m_en_pipe[s-1];
         end
         m_en_pipe[0] = m_cken;
         if (cmd_valid && (cmd_op == ctu_pkg::CMD_ENABLE)) begin
            m_cken[cmd_cluster] = 1'b1;
         end else if (cmd_valid && (cmd_op == ctu_pkg::CMD_DISABLE)) begin
            m_cken[cmd_cluster] = 1'b0;
         end
         // A new pulse command restarts the full count
         if (cmd_valid && (cmd_op == ctu_pkg::CMD_RESET)) begin
            m_rst_cnt = ctu_pkg::RESET_PULSE_CYCLES;
         end else if (m_rst_cnt > 0) begin
            m_rst_cnt--;
         end
         if (cmd_valid && (cmd_op == ctu_pkg::CMD_DBGINIT)) begin
            m_dbg_cnt = ctu_pkg::RESET_PULSE_CYCLES;
         end else if (m_dbg_cnt > 0) begin
            m_dbg_cnt--;
         end
         m_grst_l = (m_rst_cnt == 0);
         m_gdbg_l = (m_dbg_cnt == 0);
      end
      for (int h = 0; h < N; h++) begin
         m_grst_out[h] = m_chain[h*2*D + D - 1];
         m_dbg_out[h]  = m_chain[h*2*D + 2*D - 1];
      end
   end

   task automatic check_vec(input logic [N-1:0] got, input logic [N-1:0] exp,
                            input string what);
      if (got !== exp) begin
         vec_errors++;
         $display("Error at %0t ns: %s is %b, model expects %b", $time, what, got, exp);
      end
   endtask

   task automatic check_bit(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         bit_errors++;
         $display("Error at %0t ns: %s is %b, model expects %b", $time, what, got, exp);
      end
   endtask

   always @(negedge gclk) begin
      if (checking) begin
         check_vec(cluster_en, m_en_pipe[D-1], "cluster_en");
         check_vec(cluster_grst_l, m_grst_out, "cluster_grst_l");
         check_vec(dbginit_l, m_dbg_out, "dbginit_l");
         check_bit(so, m_chain[L-1], "so");
      end
   end

   task automatic send_cmd(input logic [ctu_pkg::CMD_OP_W-1:0] op,
                           input logic [ctu_pkg::CLUSTER_IDX_W-1:0] cluster);
      @(posedge gclk);
      cmd_valid   <= 1'b1;
      cmd_op      <= op;
      cmd_cluster <= cluster;
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) begin
         @(posedge gclk);
         cmd_valid <= 1'b0;
      end
   endtask

   // Mostly enable and disable commands with the odd pulse mixed in
   task automatic send_random_cmd();
      int                                pick;
      logic [ctu_pkg::CLUSTER_IDX_W-1:0] cluster;
      pick    = $urandom_range(0, 15);
      cluster = ctu_pkg::CLUSTER_IDX_W'($urandom_range(0, N - 1));
      if (pick < 13) begin
         send_cmd(pick[0] ? ctu_pkg::CMD_DISABLE : ctu_pkg::CMD_ENABLE, cluster);
      end else if (pick < 15) begin
         send_cmd(ctu_pkg::CMD_RESET, cluster);
      end else begin
         send_cmd(ctu_pkg::CMD_DBGINIT, cluster);
      end
   endtask

   // Random bits go in on si while enable traffic keeps cluster_en moving
   task automatic shift_scan(input int cycles);
      repeat (cycles) begin
         @(posedge gclk);
         se          <= 1'b1;
         si          <= 1'($urandom_range(0, 1));
         cmd_valid   <= 1'($urandom_range(0, 1));
         cmd_op      <= $urandom_range(0, 1) ? ctu_pkg::CMD_DISABLE : ctu_pkg::CMD_ENABLE;
         cmd_cluster <= ctu_pkg::CLUSTER_IDX_W'($urandom_range(0, N - 1));
      end
      @(posedge gclk);
      se        <= 1'b0;
      si        <= 1'b0;
      cmd_valid <= 1'b0;
   endtask

   initial begin
      void'($urandom(58940));
      rst_n         = 1'b0;
      cmd_valid     = 1'b0;
      cmd_op        = '0;
      cmd_cluster   = '0;
      si            = 1'b0;
      se            = 1'b0;
      vec_errors    = 0;
      bit_errors    = 0;
      assert_errors = 0;
      checking      = 1'b0;
      // The first edge clears every flop, so checks start here
      @(posedge gclk);
      checking <= 1'b1;
      repeat (4) @(posedge gclk);
      rst_n <= 1'b1;
      idle(4);
      repeat (NUM_CMDS) send_random_cmd();
      idle(6);
      // A reset pulse is restarted inside itself and a debug-init pulse lands on top
      send_cmd(ctu_pkg::CMD_RESET, '0);
      idle(3);
      send_cmd(ctu_pkg::CMD_RESET, '0);
      idle(2);
      send_cmd(ctu_pkg::CMD_DBGINIT, '0);
      idle(11);
      shift_scan(SCAN_CYCLES);
      idle(4);
      assert_errors = ctu_top_i.sequencer_i.checker_i.fail_count;
      $display("Errors: %0d vector mismatches, %0d scan mismatches, %0d assertion failures",
               vec_errors, bit_errors, assert_errors);
      if (vec_errors + bit_errors + assert_errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      #((NUM_CMDS + SCAN_CYCLES + 50) * CLK_PERIOD);
      $display("Watchdog: the run did not finish in time and was stopped");
      $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

//--- verif/ctu_checker.sv
/*
 * Concurrent checks on the command sequencer, bound to every instance.
 * All properties are off while rst_n is low.
 * Every failure also raises fail_count.
 */
`timescale 1ns/1ns
`default_nettype none

module ctu_checker (
   input logic                              gclk,
   input logic                              rst_n,
   input logic                              cmd_valid,
   input logic [ctu_pkg::CMD_OP_W-1:0]      cmd_op,
   input logic [ctu_pkg::CLUSTER_IDX_W-1:0] cmd_cluster,
   input logic [ctu_pkg::NUM_CLUSTERS-1:0]  global_cken,
   input logic                              grst_l,
   input logic                              gdbginit_l
);

   logic enable_strobe;
   logic reset_strobe;

   // Number of property failures seen so far
   int   fail_count = 0;

   assign enable_strobe = cmd_valid && (cmd_op == ctu_pkg::CMD_ENABLE);
   assign reset_strobe  = cmd_valid && (cmd_op == ctu_pkg::CMD_RESET);

   // The addressed bit is set one edge after the strobe
   enable_sets_bit: assert property (
      @(posedge gclk) disable iff (!rst_n)
      enable_strobe |=> global_cken[$past(cmd_cluster)]
   ) else begin
      fail_count++;
      $error("Enable strobe did not set the addressed global_cken bit");
   end

   // A reset pulse is low for the whole count
   reset_pulse_held: assert property (
      @(posedge gclk) disable iff (!rst_n)
      reset_strobe |=> !grst_l [*ctu_pkg::RESET_PULSE_CYCLES]
   ) else begin
      fail_count++;
      $error("grst_l rose before the reset pulse count ran out");
   end

   // With no fresh reset command, the pulse ends after the count
   reset_pulse_bounded: assert property (
      @(posedge gclk) disable iff (!rst_n)
      reset_strobe ##1 (!reset_strobe) [*ctu_pkg::RESET_PULSE_CYCLES] |=> grst_l
   ) else begin
      fail_count++;
      $error("grst_l stayed low longer than the reset pulse");
   end

   no_unknown_outputs: assert property (
      @(posedge gclk) disable iff (!rst_n)
      !$isunknown({global_cken, grst_l, gdbginit_l})
   ) else begin
      fail_count++;
      $error("Sequencer output is unknown after reset");
   end

endmodule

bind ctu_sequencer ctu_checker checker_i (.*);

`default_nettype wire

//--- verilog/ctu_top.sv
/*
 * Clock-control top: the sequencer feeding one header per cluster.
 * A command shows at the cluster outputs three edges after it is driven.
 * The scan chain enters header 0 and leaves from the last header,
 * SCAN_LEN flops long.
 */
`timescale 1ns/1ns
`default_nettype none

module ctu_top (
   input  logic                              gclk,
   input  logic                              rst_n,
   input  logic                              cmd_valid,
   input  logic [ctu_pkg::CMD_OP_W-1:0]      cmd_op,
   input  logic [ctu_pkg::CLUSTER_IDX_W-1:0] cmd_cluster,
   input  logic                              si,
   input  logic                              se,
   output logic [ctu_pkg::NUM_CLUSTERS-1:0]  cluster_en,
   output logic [ctu_pkg::NUM_CLUSTERS-1:0]  cluster_grst_l,
   output logic [ctu_pkg::NUM_CLUSTERS-1:0]  dbginit_l,
   output logic                              so
);

   // Per-cluster enables and the shared global levels
   logic [ctu_pkg::NUM_CLUSTERS-1:0] global_cken;
   logic                             grst_l;
   logic                             gdbginit_l;

   // Scan links, entry 0 is si and the last entry is so
   logic [ctu_pkg::NUM_CLUSTERS:0]   scan_link;

   ctu_sequencer sequencer_i (
      .gclk        (gclk),
      .rst_n       (rst_n),
      .cmd_valid   (cmd_valid),
      .cmd_op      (cmd_op),
      .cmd_cluster (cmd_cluster),
      .global_cken (global_cken),
      .grst_l      (grst_l),
      .gdbginit_l  (gdbginit_l)
   );

   assign scan_link[0] = si;

   for (genvar i = 0; i < ctu_pkg::NUM_CLUSTERS; i++) begin : g_header
      // Each header hands its so to the next header's si
      cluster_header header_i (
         .gclk           (gclk),
         .rst_n          (rst_n),
         .se             (se),
         .si             (scan_link[i]),
         .cluster_cken   (global_cken[i]),
         .grst_l         (grst_l),
         .gdbginit_l     (gdbginit_l),
         .cluster_en     (cluster_en[i]),
         .cluster_grst_l (cluster_grst_l[i]),
         .dbginit_l      (dbginit_l[i]),
         .so             (scan_link[i+1])
      );
   end

   assign so = scan_link[ctu_pkg::NUM_CLUSTERS];

endmodule

`default_nettype wire

//--- verilog/ctu_sequencer.sv
/*
 * Command sequencer. Takes one command per cmd_valid strobe, with no
 * back-pressure. All outputs are registered and change one edge after
 * the strobe is sampled. A pulse command arriving during a pulse of the
 * same kind reloads its counter, which stretches the pulse.
 */
`timescale 1ns/1ns
`default_nettype none

module ctu_sequencer (
   input  logic                              gclk,
   input  logic                              rst_n,
   input  logic                              cmd_valid,
   input  logic [ctu_pkg::CMD_OP_W-1:0]      cmd_op,
   input  logic [ctu_pkg::CLUSTER_IDX_W-1:0] cmd_cluster,
   output logic [ctu_pkg::NUM_CLUSTERS-1:0]  global_cken,
   output logic                              grst_l,
   output logic                              gdbginit_l
);

   // Enable mask with one bit per cluster
   logic [ctu_pkg::NUM_CLUSTERS-1:0] cken_q;
   logic [ctu_pkg::NUM_CLUSTERS-1:0] cken_nxt;

   // Low cycles left in each pulse
   // A counter at zero means no pulse is running
   logic [ctu_pkg::PULSE_CNT_W-1:0] rst_cnt_q;
   logic [ctu_pkg::PULSE_CNT_W-1:0] rst_cnt_nxt;
   logic [ctu_pkg::PULSE_CNT_W-1:0] dbg_cnt_q;
   logic [ctu_pkg::PULSE_CNT_W-1:0] dbg_cnt_nxt;

   // Registered active-low levels
   logic grst_l_q;
   logic gdbginit_l_q;

   // Decoded pulse requests
   logic rst_fire;
   logic dbg_fire;

   // Both counters share this rule, so they run side by side unaware
   // of each other and their pulses may overlap freely
   function automatic logic [ctu_pkg::PULSE_CNT_W-1:0] pulse_cnt_next(
      input logic [ctu_pkg::PULSE_CNT_W-1:0] cnt,
      input logic                            fire
   );
      logic [ctu_pkg::PULSE_CNT_W-1:0] nxt;
      if (fire) begin
         nxt = ctu_pkg::PULSE_CNT_W'(ctu_pkg::RESET_PULSE_CYCLES);
      end else if (cnt != '0) begin
         nxt = cnt - 1'b1;
      end else begin
         nxt = '0;
      end
      return nxt;
   endfunction

   // The cluster index is ignored for the pulse opcodes
   assign rst_fire = cmd_valid && (cmd_op == ctu_pkg::CMD_RESET);
   assign dbg_fire = cmd_valid && (cmd_op == ctu_pkg::CMD_DBGINIT);

   // Enable and disable touch only the addressed bit
   always_comb begin
      cken_nxt = cken_q;
      if (cmd_valid && (cmd_op == ctu_pkg::CMD_ENABLE)) begin
         cken_nxt[cmd_cluster] = 1'b1;
      end
      if (cmd_valid && (cmd_op == ctu_pkg::CMD_DISABLE)) begin
         cken_nxt[cmd_cluster] = 1'b0;
      end
   end

   assign rst_cnt_nxt = pulse_cnt_next(rst_cnt_q, rst_fire);
   assign dbg_cnt_nxt = pulse_cnt_next(dbg_cnt_q, dbg_fire);

   // The level is taken from the next count, so a load of N keeps the
   // line low for exactly N edges
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         cken_q       <= '0;
         rst_cnt_q    <= '0;
         dbg_cnt_q    <= '0;
         // Both global lines are held asserted through reset
         grst_l_q     <= 1'b0;
         gdbginit_l_q <= 1'b0;
      end else begin
         cken_q       <= cken_nxt;
         rst_cnt_q    <= rst_cnt_nxt;
         dbg_cnt_q    <= dbg_cnt_nxt;
         grst_l_q     <= (rst_cnt_nxt == '0);
         gdbginit_l_q <= (dbg_cnt_nxt == '0);
      end
   end

   assign global_cken = cken_q;
   assign grst_l      = grst_l_q;
   assign gdbginit_l  = gdbginit_l_q;

endmodule

`default_nettype wire

//--- verilog/cluster_header.sv
/*
 * Per-cluster header. The clock enable is only resynchronized, not
 * applied, so the cluster still runs on gclk.
 * The enable synchronizer is off the scan chain and keeps capturing
 * while se is high. Scan order is reset repeater, then debug-init.
 */
`timescale 1ns/1ns
`default_nettype none

module cluster_header (
   input  logic gclk,
   input  logic rst_n,
   input  logic se,
   input  logic si,
   input  logic cluster_cken,
   input  logic grst_l,
   input  logic gdbginit_l,
   output logic cluster_en,
   output logic cluster_grst_l,
   output logic dbginit_l,
   output logic so
);

   // Enable synchronizer stages, no scan hook-up
   logic [ctu_pkg::SYNC_DEPTH-1:0] cken_sync_q;

   // Scan link from the reset repeater into the debug-init repeater
   logic rst_sync_so;

   // Enable reads as off in reset, whatever the sequencer drives
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         cken_sync_q <= '0;
      end else begin
         cken_sync_q <= {cken_sync_q[ctu_pkg::SYNC_DEPTH-2:0], cluster_cken};
      end
   end

   assign cluster_en = cken_sync_q[ctu_pkg::SYNC_DEPTH-1];

   // Reset repeater is first on this header's piece of the chain
   reset_repeater rst_repeater (
      .gclk     (gclk),
      .rst_n    (rst_n),
      .se       (se),
      .async_in (grst_l),
      .si       (si),
      .sync_out (cluster_grst_l),
      .so       (rst_sync_so)
   );

   // Debug-init repeater closes the chain and drives the header's so
   reset_repeater dbginit_repeater (
      .gclk     (gclk),
      .rst_n    (rst_n),
      .se       (se),
      .async_in (gdbginit_l),
      .si       (rst_sync_so),
      .sync_out (dbginit_l),
      .so       (so)
   );

endmodule

`default_nettype wire

//--- verilog/reset_repeater.sv
/*
 * Flop repeater for an active-low global level, SYNC_DEPTH stages deep.
 * rst_n clears every stage, so the output reads asserted (low) in reset.
 * With se high the stages form a plain shift register from si to so.
 */
`timescale 1ns/1ns
`default_nettype none

module reset_repeater (
   input  logic gclk,
   input  logic rst_n,
   input  logic se,
   input  logic async_in,
   input  logic si,
   output logic sync_out,
   output logic so
);

   // Stage 0 is the capture flop, the top stage drives both outputs
   logic [ctu_pkg::SYNC_DEPTH-1:0] sync_q;

   // First stage picks the scan input over the functional input
   logic stage0_d;

   assign stage0_d = se ? si : async_in;

   // Later stages take the previous stage in both modes
   always_ff @(posedge gclk) begin
      if (!rst_n) begin
         sync_q <= '0;
      end else begin
         sync_q <= {sync_q[ctu_pkg::SYNC_DEPTH-2:0], stage0_d};
      end
   end

   // The functional output and the scan output are the same flop
   assign sync_out = sync_q[ctu_pkg::SYNC_DEPTH-1];
   assign so       = sync_q[ctu_pkg::SYNC_DEPTH-1];

endmodule

`default_nettype wire

//--- verilog/ctu_pkg.sv
/*
 * Shared constants for the clock-control slice.
 * The enable, reset and debug-init vectors are all NUM_CLUSTERS bits wide.
 * The opcodes fit in CMD_OP_W bits and are decoded only by the sequencer.
 */
`default_nettype none

package ctu_pkg;

   // Number of clusters, each with its own header
   localparam int NUM_CLUSTERS = 4;

   // Width of the cluster index carried with a command
   localparam int CLUSTER_IDX_W = $clog2(NUM_CLUSTERS);

   // Flops in every repeater and in the enable synchronizer
   localparam int SYNC_DEPTH = 2;

   // Two repeaters per header, all of them chained for scan
   localparam int SCAN_LEN = NUM_CLUSTERS * 2 * SYNC_DEPTH;

   // A reset or debug-init pulse holds its line low this many cycles
   localparam int RESET_PULSE_CYCLES = 8;

   // Pulse counters must hold RESET_PULSE_CYCLES itself
   localparam int PULSE_CNT_W = $clog2(RESET_PULSE_CYCLES + 1);

   // Command opcodes
   localparam int CMD_OP_W = 2;
   localparam logic [CMD_OP_W-1:0] CMD_ENABLE  = 2'b00;
   localparam logic [CMD_OP_W-1:0] CMD_DISABLE = 2'b01;
   // The two pulse opcodes act on every cluster at once
   localparam logic [CMD_OP_W-1:0] CMD_RESET   = 2'b10;
   localparam logic [CMD_OP_W-1:0] CMD_DBGINIT = 2'b11;

endpackage

`default_nettype wire
